/* design/fetch_pkg.sv */
package fetch_pkg;

  // Address, instruction and parcel widths used throughout the front end.
  typedef logic [63:0] pc_t;
  typedef logic [31:0] instr_t;
  typedef logic [15:0] half_t;

  // Half-word strobe. Bit 0 selects the lower parcel and bit 1 the upper parcel.
  typedef logic [1:0] strb_t;

  localparam strb_t BOTH_HALVES = 2'b11;
  localparam strb_t UPPER_HALF  = 2'b10;

  // The two low opcode bits of a parcel are 2'b11 only for a 32-bit instruction.
  localparam logic [1:0] OPC_32BIT = 2'b11;

  typedef enum logic {
    IF_PREFETCH = 1'b0,
    IF_REDIRECT = 1'b1
  } if_reason_e;

  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGNED   = 4'd0,
    EXC_INSTR_ACCESS_FAULT = 4'd1
  } exc_cause_e;

  // Configuration register map.
  typedef logic [1:0] cfg_addr_t;

  localparam cfg_addr_t REG_REDIRECT_PC = 2'd0;
  localparam cfg_addr_t REG_FAULT_BASE  = 2'd1;
  localparam cfg_addr_t REG_FAULT_LIMIT = 2'd2;
  localparam cfg_addr_t REG_CTRL        = 2'd3;

  // Bit position of the fetch enable inside REG_CTRL.
  localparam int CTRL_ENABLE_BIT = 0;

  localparam int CFG_DATA_W = 64;

  // Distance between two consecutive fetch words.
  localparam pc_t WORD_STEP = 64'd4;

endpackage

/* design/fetch_word_if.sv */
`timescale 1ns/1ps

interface fetch_word_if;
  import fetch_pkg::*;

  logic       word_valid;
  logic       word_ready;
  pc_t        word_pc;
  strb_t      word_strb;
  instr_t     word_instr;
  if_reason_e word_reason;
  logic       word_exception;
  exc_cause_e word_ex_code;

  // The fetcher drives the word and its tags.
  modport producer (
    output word_valid,
    input  word_ready,
    output word_pc,
    output word_strb,
    output word_instr,
    output word_reason,
    output word_exception,
    output word_ex_code
  );

  modport consumer (
    input  word_valid,
    output word_ready,
    input  word_pc,
    input  word_strb,
    input  word_instr,
    input  word_reason,
    input  word_exception,
    input  word_ex_code
  );

endinterface

/* design/fetch_instr_if.sv */
`timescale 1ns/1ps

interface fetch_instr_if;
  import fetch_pkg::*;

  logic       instr_valid;
  logic       instr_ready;
  pc_t        instr_pc;
  instr_t     instr_word;
  if_reason_e instr_reason;
  logic       instr_ex_valid;
  exc_cause_e instr_ex_cause;
  pc_t        instr_ex_tval;

  modport producer (
    output instr_valid,
    input  instr_ready,
    output instr_pc,
    output instr_word,
    output instr_reason,
    output instr_ex_valid,
    output instr_ex_cause,
    output instr_ex_tval
  );

  modport consumer (
    input  instr_valid,
    output instr_ready,
    input  instr_pc,
    input  instr_word,
    input  instr_reason,
    input  instr_ex_valid,
    input  instr_ex_cause,
    input  instr_ex_tval
  );

endinterface

/* design/fetch_ctrl_regs.sv */
`timescale 1ns/1ps

module fetch_ctrl_regs (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             cfg_we_i,
  input  fetch_pkg::cfg_addr_t             cfg_addr_i,
  input  logic [fetch_pkg::CFG_DATA_W-1:0] cfg_wdata_i,

  output logic                             redirect_o,
  output fetch_pkg::pc_t                   redirect_pc_o,
  output fetch_pkg::pc_t                   fault_base_o,
  output fetch_pkg::pc_t                   fault_limit_o,
  output logic                             enable_o
);
  import fetch_pkg::*;

  logic redirect_q;
  pc_t  redirect_pc_q;
  pc_t  fault_base_q;
  pc_t  fault_limit_q;
  logic enable_q;

  logic wr_redirect;
  logic wr_base;
  logic wr_limit;
  logic wr_ctrl;

  assign wr_redirect = cfg_we_i && (cfg_addr_i == REG_REDIRECT_PC);
  assign wr_base     = cfg_we_i && (cfg_addr_i == REG_FAULT_BASE);
  assign wr_limit    = cfg_we_i && (cfg_addr_i == REG_FAULT_LIMIT);
  assign wr_ctrl     = cfg_we_i && (cfg_addr_i == REG_CTRL);

  // A redirect write only starts fetching while the front end is enabled.
  // Equal bounds after reset describe an empty fault window.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      redirect_q    <= 1'b0;
      enable_q      <= 1'b0;
      fault_base_q  <= '0;
      fault_limit_q <= '0;
    end else begin
      redirect_q <= wr_redirect && enable_q;
      if (wr_ctrl) begin
        enable_q <= cfg_wdata_i[CTRL_ENABLE_BIT];
      end
      if (wr_base) begin
        fault_base_q <= cfg_wdata_i;
      end
      if (wr_limit) begin
        fault_limit_q <= cfg_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_redirect) begin
      redirect_pc_q <= cfg_wdata_i;
    end
  end

  assign redirect_o    = redirect_q;
  assign redirect_pc_o = redirect_pc_q;
  assign fault_base_o  = fault_base_q;
  assign fault_limit_o = fault_limit_q;
  assign enable_o      = enable_q;

endmodule

/* design/word_fetcher.sv */
`timescale 1ns/1ps

module word_fetcher (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              redirect_i,
  input  fetch_pkg::pc_t    redirect_pc_i,
  input  fetch_pkg::pc_t    fault_base_i,
  input  fetch_pkg::pc_t    fault_limit_i,
  input  logic              enable_i,

  output logic              mem_req_o,
  output fetch_pkg::pc_t    mem_addr_o,
  input  fetch_pkg::instr_t mem_rdata_i,

  fetch_word_if.producer    word
);
  import fetch_pkg::*;

  // IDLE means the word buffer is empty and a request may go out.
  // HALTED is the resting state after reset and after an exception word.
  typedef enum logic [1:0] {
    IDLE,
    WAIT_RSP,
    HOLD,
    HALTED
  } fetch_state_e;

  fetch_state_e state_q;
  logic         first_q;
  logic         fault_q;
  pc_t          next_pc_q;

  pc_t          buf_pc_q;
  strb_t        buf_strb_q;
  instr_t       buf_instr_q;
  if_reason_e   buf_reason_q;
  logic         buf_exc_q;
  exc_cause_e   buf_code_q;

  pc_t          req_addr;
  logic         in_window;
  logic         xfer;
  logic         fetch_now;

  assign req_addr  = {next_pc_q[63:2], 2'b00};
  assign in_window = (req_addr >= fault_base_i) && (req_addr < fault_limit_i);
  assign xfer      = word.word_valid && word.word_ready;

  // A new request goes out from an empty buffer, or in the cycle the held
  // word is taken. A redirect pulse suppresses it.
  assign fetch_now = enable_i && !redirect_i &&
                     ((state_q == IDLE) || ((state_q == HOLD) && xfer && !buf_exc_q));

  // Faulting addresses never reach the memory.
  assign mem_req_o  = fetch_now && !in_window;
  assign mem_addr_o = req_addr;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= HALTED;
      first_q <= 1'b0;
      fault_q <= 1'b0;
    end else if (redirect_i) begin
      // An odd target goes straight to an exception word.
      first_q <= 1'b1;
      state_q <= redirect_pc_i[0] ? HOLD : IDLE;
    end else begin
      if (fetch_now) begin
        fault_q <= in_window;
      end
      case (state_q)
        IDLE: begin
          if (fetch_now) begin
            state_q <= WAIT_RSP;
          end
        end
        WAIT_RSP: begin
          state_q <= HOLD;
          first_q <= 1'b0;
        end
        HOLD: begin
          if (xfer) begin
            if (buf_exc_q) begin
              state_q <= HALTED;
            end else if (fetch_now) begin
              state_q <= WAIT_RSP;
            end else begin
              state_q <= IDLE;
            end
          end
        end
        default: begin
          state_q <= HALTED;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (redirect_i) begin
      next_pc_q    <= redirect_pc_i;
      buf_pc_q     <= redirect_pc_i;
      buf_strb_q   <= redirect_pc_i[1] ? UPPER_HALF : BOTH_HALVES;
      buf_instr_q  <= '0;
      buf_reason_q <= IF_REDIRECT;
      buf_exc_q    <= redirect_pc_i[0];
      buf_code_q   <= EXC_INSTR_MISALIGNED;
    end else if (state_q == WAIT_RSP) begin
      // The response of last cycle's request is valid now.
      next_pc_q    <= req_addr + WORD_STEP;
      buf_pc_q     <= next_pc_q;
      buf_strb_q   <= next_pc_q[1] ? UPPER_HALF : BOTH_HALVES;
      buf_instr_q  <= mem_rdata_i;
      buf_reason_q <= first_q ? IF_REDIRECT : IF_PREFETCH;
      buf_exc_q    <= fault_q;
      buf_code_q   <= EXC_INSTR_ACCESS_FAULT;
    end
  end

  // The held word is withdrawn in the redirect cycle so that nothing of the
  // old stream follows the redirect.
  assign word.word_valid     = (state_q == HOLD) && !redirect_i;
  assign word.word_pc        = buf_pc_q;
  assign word.word_strb      = buf_strb_q;
  assign word.word_instr     = buf_instr_q;
  assign word.word_reason    = buf_reason_q;
  assign word.word_exception = buf_exc_q;
  assign word.word_ex_code   = buf_code_q;

endmodule

/* design/instr_aligner.sv */
`timescale 1ns/1ps

module instr_aligner (
  input  logic            clk_i,
  input  logic            rst_ni,

  fetch_word_if.consumer  word,
  fetch_instr_if.producer instr
);
  import fetch_pkg::*;

  logic       prev_valid_q;
  logic       prev_valid_d;
  pc_t        prev_pc_q;
  if_reason_e prev_reason_q;
  if_reason_e prev_reason_d;
  half_t      prev_instr_q;
  logic       second_half_q;
  logic       second_half_d;

  half_t      lo_half;
  half_t      hi_half;
  logic       hi_is_32;
  logic       continues;

  assign lo_half   = word.word_instr[15:0];
  assign hi_half   = word.word_instr[31:16];
  assign hi_is_32  = (hi_half[1:0] == OPC_32BIT);

  // A leftover parcel only counts when the stream has not been redirected.
  assign continues = prev_valid_q && (word.word_reason == IF_PREFETCH);

  always_comb begin
    prev_valid_d  = prev_valid_q;
    second_half_d = second_half_q;
    prev_reason_d = IF_PREFETCH;
    word.word_ready = 1'b0;

    instr.instr_valid    = 1'b0;
    instr.instr_pc       = '0;
    instr.instr_word     = '0;
    instr.instr_reason   = IF_PREFETCH;
    instr.instr_ex_valid = 1'b0;
    instr.instr_ex_cause = EXC_INSTR_MISALIGNED;
    instr.instr_ex_tval  = '0;

    if (!word.word_valid) begin
      // The fetcher only drops a word on a redirect, so a pending upper
      // parcel no longer belongs to the stream.
      second_half_d = 1'b0;
    end else if (word.word_exception) begin
      instr.instr_valid    = 1'b1;
      instr.instr_pc       = continues ? prev_pc_q : word.word_pc;
      instr.instr_reason   = continues ? prev_reason_q : word.word_reason;
      instr.instr_ex_valid = 1'b1;
      instr.instr_ex_cause = word.word_ex_code;
      instr.instr_ex_tval  = word.word_pc;
      if (instr.instr_ready) begin
        prev_valid_d    = 1'b0;
        word.word_ready = 1'b1;
      end
    end else if (word.word_strb == UPPER_HALF && hi_is_32) begin
      // First half of a 32-bit instruction at a target with bit 1 set.
      // It is kept as leftover and nothing goes out yet.
      prev_valid_d    = 1'b1;
      second_half_d   = 1'b0;
      prev_reason_d   = word.word_reason;
      word.word_ready = 1'b1;
    end else begin
      if (instr.instr_ready) begin
        prev_valid_d  = 1'b0;
        second_half_d = 1'b0;
      end

      if (word.word_strb == UPPER_HALF || second_half_q) begin
        // Compressed instruction in the upper parcel.
        instr.instr_valid  = 1'b1;
        instr.instr_pc     = {word.word_pc[63:2], 2'b10};
        instr.instr_reason = second_half_q ? IF_PREFETCH : word.word_reason;
        instr.instr_word   = {16'd0, hi_half};
        word.word_ready    = instr.instr_ready;
      end else begin
        instr.instr_valid = 1'b1;
        if (continues) begin
          // The lower parcel completes the instruction started by the leftover.
          instr.instr_pc     = prev_pc_q;
          instr.instr_reason = prev_reason_q;
          instr.instr_word   = {lo_half, prev_instr_q};
        end else if (lo_half[1:0] == OPC_32BIT) begin
          instr.instr_pc     = word.word_pc;
          instr.instr_reason = word.word_reason;
          instr.instr_word   = word.word_instr;
        end else begin
          instr.instr_pc     = word.word_pc;
          instr.instr_reason = word.word_reason;
          instr.instr_word   = {16'd0, lo_half};
        end

        if (instr.instr_ready) begin
          if (!continues && lo_half[1:0] == OPC_32BIT) begin
            word.word_ready = 1'b1;
          end else begin
            // The upper parcel is either the start of the next 32-bit
            // instruction or a compressed one that goes out next.
            prev_valid_d = 1'b1;
            if (hi_is_32) begin
              word.word_ready = 1'b1;
            end else begin
              second_half_d = 1'b1;
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_valid_q  <= 1'b0;
      second_half_q <= 1'b0;
    end else begin
      prev_valid_q  <= prev_valid_d;
      second_half_q <= second_half_d;
    end
  end

  // The upper parcel of every consumed word is kept as a possible leftover.
  always_ff @(posedge clk_i) begin
    if (word.word_ready) begin
      prev_instr_q  <= hi_half;
      prev_pc_q     <= {word.word_pc[63:2], 2'b10};
      prev_reason_q <= prev_reason_d;
    end
  end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  input  logic                             cfg_we_i,
  input  fetch_pkg::cfg_addr_t             cfg_addr_i,
  input  logic [fetch_pkg::CFG_DATA_W-1:0] cfg_wdata_i,

  output logic                             mem_req_o,
  output fetch_pkg::pc_t                   mem_addr_o,
  input  fetch_pkg::instr_t                mem_rdata_i,

  output logic                             instr_valid_o,
  input  logic                             instr_ready_i,
  output fetch_pkg::pc_t                   instr_pc_o,
  output fetch_pkg::instr_t                instr_word_o,
  output fetch_pkg::if_reason_e            instr_reason_o,
  output logic                             instr_ex_valid_o,
  output fetch_pkg::exc_cause_e            instr_ex_cause_o,
  output fetch_pkg::pc_t                   instr_ex_tval_o
);
  import fetch_pkg::*;

  logic redirect;
  pc_t  redirect_pc;
  pc_t  fault_base;
  pc_t  fault_limit;
  logic enable;

  fetch_word_if  word_bus ();
  fetch_instr_if instr_bus ();

  fetch_ctrl_regs fetch_ctrl_regs_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc),
    .fault_base_o  (fault_base),
    .fault_limit_o (fault_limit),
    .enable_o      (enable)
  );

  word_fetcher word_fetcher_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .fault_base_i  (fault_base),
    .fault_limit_i (fault_limit),
    .enable_i      (enable),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_rdata_i   (mem_rdata_i),
    .word          (word_bus.producer)
  );

  instr_aligner instr_aligner_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .word   (word_bus.consumer),
    .instr  (instr_bus.producer)
  );

  // The aligned instruction leaves the design on plain ports.
  assign instr_valid_o         = instr_bus.instr_valid;
  assign instr_bus.instr_ready = instr_ready_i;
  assign instr_pc_o            = instr_bus.instr_pc;
  assign instr_word_o          = instr_bus.instr_word;
  assign instr_reason_o        = instr_bus.instr_reason;
  assign instr_ex_valid_o      = instr_bus.instr_ex_valid;
  assign instr_ex_cause_o      = instr_bus.instr_ex_cause;
  assign instr_ex_tval_o       = instr_bus.instr_ex_tval;

endmodule

/* test/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              mem_req_i,
  input fetch_pkg::pc_t    mem_addr_i,
  input logic              instr_valid_i,
  input logic              instr_ready_i,
  input fetch_pkg::pc_t    instr_pc_i,
  input fetch_pkg::instr_t instr_word_i
);

  int fail_count = 0;

  // Flops may still be unknown on the first reset edge, so only later reset edges count.
  property quiet_in_reset;
    @(posedge clk_i) (!rst_ni && $past(!rst_ni)) |-> (!instr_valid_i && !mem_req_i);
  endproperty

  // A stalled instruction keeps its address and encoding until it is taken.
  property held_while_stalled;
    @(posedge clk_i) disable iff (!rst_ni)
      (instr_valid_i && !instr_ready_i) ##1 instr_valid_i |->
        ($stable(instr_pc_i) && $stable(instr_word_i));
  endproperty

  // A request is word aligned and is never followed by another in the next cycle.
  property aligned_single_request;
    @(posedge clk_i) disable iff (!rst_ni)
      mem_req_i |-> (mem_addr_i[1:0] == 2'b00) ##1 !mem_req_i;
  endproperty

  quiet_in_reset_a: assert property (quiet_in_reset)
    else begin
      $error("Instruction valid or memory request seen during reset");
      fail_count++;
    end

  held_while_stalled_a: assert property (held_while_stalled)
    else begin
      $error("Instruction changed while stalled: pc %h word %h", instr_pc_i, instr_word_i);
      fail_count++;
    end

  aligned_single_request_a: assert property (aligned_single_request)
    else begin
      $error("Memory request unaligned or directly followed by another at %h", mem_addr_i);
      fail_count++;
    end

endmodule

bind fetch_top fetch_checker fetch_checker_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .mem_req_i     (mem_req_o),
  .mem_addr_i    (mem_addr_o),
  .instr_valid_i (instr_valid_o),
  .instr_ready_i (instr_ready_i),
  .instr_pc_i    (instr_pc_o),
  .instr_word_i  (instr_word_o)
);

/* test/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic                  cfg_we;
  cfg_addr_t             cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  mem_req;
  pc_t                   mem_addr;
  instr_t                mem_rdata;
  logic                  instr_valid;
  logic                  instr_ready;
  pc_t                   instr_pc;
  instr_t                instr_word;
  if_reason_e            instr_reason;
  logic                  instr_ex_valid;
  exc_cause_e            instr_ex_cause;
  pc_t                   instr_ex_tval;

  instr_t     mem [0:255];
  pc_t        exp_pc[$];
  instr_t     exp_word[$];
  if_reason_e exp_reason[$];

  // Fields of the most recent instruction transfer.
  pc_t        obs_pc;
  instr_t     obs_word;
  if_reason_e obs_reason;
  logic       obs_ex_valid;
  exc_cause_e obs_ex_cause;
  pc_t        obs_ex_tval;

  integer     seed;
  int         errors;
  int         checks;
  int         assert_fails;

  fetch_top fetch_top_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .cfg_we_i         (cfg_we),
    .cfg_addr_i       (cfg_addr),
    .cfg_wdata_i      (cfg_wdata),
    .mem_req_o        (mem_req),
    .mem_addr_o       (mem_addr),
    .mem_rdata_i      (mem_rdata),
    .instr_valid_o    (instr_valid),
    .instr_ready_i    (instr_ready),
    .instr_pc_o       (instr_pc),
    .instr_word_o     (instr_word),
    .instr_reason_o   (instr_reason),
    .instr_ex_valid_o (instr_ex_valid),
    .instr_ex_cause_o (instr_ex_cause),
    .instr_ex_tval_o  (instr_ex_tval)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Instruction memory with a fixed one-cycle read latency.
  always @(posedge clk) begin
    if (mem_req) begin
      mem_rdata <= mem[mem_addr[9:2]];
    end
  end

  function automatic void write_parcel(input pc_t addr, input half_t value);
    if (addr[1]) begin
      mem[addr[9:2]][31:16] = value;
    end else begin
      mem[addr[9:2]][15:0] = value;
    end
  endfunction

  function automatic half_t read_parcel(input pc_t addr);
    instr_t w;
    w = mem[addr[9:2]];
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  // The program repeats the length pattern C C W C W C C W over 22 bytes,
  // so both word alignments of every instruction kind occur.
  task automatic load_program();
    pc_t        pc;
    int         i;
    int         k;
    logic [7:0] layout;
    layout = 8'b1001_0100;
    for (i = 0; i < 256; i++) begin
      mem[i] = {i[7:0] ^ 8'h5a, i[7:0], ~i[7:0], 8'hc3};
    end
    pc = '0;
    k = 0;
    while (pc < 64'd1020) begin
      if (layout[k % 8]) begin
        write_parcel(pc, {pc[14:1], 2'b11});
        write_parcel(pc + 2, pc[15:0] ^ 16'h5a5a);
        pc = pc + 4;
      end else begin
        write_parcel(pc, {pc[14:1], 2'b01});
        pc = pc + 2;
      end
      k++;
    end
  endtask

  // Walks the memory parcel by parcel from start and queues every
  // instruction that begins below stop.
  task automatic build_model(input pc_t start, input pc_t stop);
    pc_t   pc;
    half_t lo;
    logic  first;
    exp_pc.delete();
    exp_word.delete();
    exp_reason.delete();
    pc = start;
    first = 1'b1;
    while (pc < stop) begin
      lo = read_parcel(pc);
      exp_pc.push_back(pc);
      exp_reason.push_back(first ? IF_REDIRECT : IF_PREFETCH);
      if (lo[1:0] == 2'b11) begin
        exp_word.push_back({read_parcel(pc + 2), lo});
        pc = pc + 4;
      end else begin
        exp_word.push_back({16'h0000, lo});
        pc = pc + 2;
      end
      first = 1'b0;
    end
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAIL %s %s expected %h actual %h", test, field, exp, act);
      errors++;
    end
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input logic [CFG_DATA_W-1:0] data);
    cfg_we = 1'b1;
    cfg_addr = addr;
    cfg_wdata = data;
    @(posedge clk);
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic redirect_to(input pc_t target);
    instr_ready = 1'b0;
    cfg_write(REG_REDIRECT_PC, target);
  endtask

  task automatic wait_transfer(input string test, input bit random_ready, output bit got);
    int cycles;
    int rnd;
    got = 1'b0;
    cycles = 0;
    while (!got && cycles < 64) begin
      rnd = $random(seed);
      instr_ready = random_ready ? rnd[0] : 1'b1;
      // Outputs have settled here and hold until the next rising edge.
      #1;
      if (instr_valid && instr_ready) begin
        obs_pc = instr_pc;
        obs_word = instr_word;
        obs_reason = instr_reason;
        obs_ex_valid = instr_ex_valid;
        obs_ex_cause = instr_ex_cause;
        obs_ex_tval = instr_ex_tval;
        got = 1'b1;
      end
      @(posedge clk);
      @(negedge clk);
      cycles++;
    end
    if (!got) begin
      $display("%s: no instruction transfer within 64 cycles", test);
      errors++;
    end
  endtask

  task automatic compare_stream(input string test, input bit random_ready);
    bit got;
    int i;
    for (i = 0; i < exp_pc.size(); i++) begin
      wait_transfer(test, random_ready, got);
      if (!got) begin
        return;
      end
      check_field(test, "pc", exp_pc[i], obs_pc);
      check_field(test, "word", exp_word[i], obs_word);
      check_field(test, "reason", exp_reason[i], obs_reason);
      check_field(test, "ex_valid", 64'd0, obs_ex_valid);
    end
  endtask

  task automatic expect_exception(input string test, input exc_cause_e cause, input pc_t tval);
    bit got;
    wait_transfer(test, 1'b0, got);
    if (got) begin
      check_field(test, "ex_valid", 64'd1, obs_ex_valid);
      check_field(test, "ex_cause", cause, obs_ex_cause);
      check_field(test, "ex_tval", tval, obs_ex_tval);
    end
  endtask

  task automatic expect_silence(input string test, input int cycles);
    int i;
    instr_ready = 1'b1;
    for (i = 0; i < cycles; i++) begin
      #1;
      checks++;
      assert (!instr_valid) else begin
        $display("%s: unexpected transfer at pc %h after the exception", test, instr_pc);
        errors++;
      end
      @(posedge clk);
      @(negedge clk);
    end
  endtask

  task automatic aligned_redirect();
    redirect_to(64'h0);
    build_model(64'h0, 64'h60);
    compare_stream("aligned_redirect", 1'b0);
  endtask

  // A 32-bit instruction starts at 0xA and ends in the next word.
  task automatic upper_half_target();
    redirect_to(64'hA);
    build_model(64'hA, 64'h48);
    compare_stream("upper_half_target", 1'b0);
  endtask

  task automatic random_backpressure();
    redirect_to(64'h80);
    build_model(64'h80, 64'h140);
    compare_stream("random_backpressure", 1'b1);
  endtask

  // The word at 0x10 starts with a whole instruction, so nothing straddles into it.
  task automatic access_fault_window();
    cfg_write(REG_FAULT_BASE, 64'h10);
    cfg_write(REG_FAULT_LIMIT, 64'h14);
    redirect_to(64'h0);
    build_model(64'h0, 64'h10);
    compare_stream("access_fault_window", 1'b0);
    expect_exception("access_fault_window", EXC_INSTR_ACCESS_FAULT, 64'h10);
    expect_silence("access_fault_window", 40);
    cfg_write(REG_FAULT_LIMIT, 64'h0);
    cfg_write(REG_FAULT_BASE, 64'h0);
  endtask

  task automatic misaligned_target();
    redirect_to(64'h21);
    expect_exception("misaligned_target", EXC_INSTR_MISALIGNED, 64'h21);
    expect_silence("misaligned_target", 20);
  endtask

  task automatic leftover_discard();
    int cycles;
    redirect_to(64'h8);
    build_model(64'h8, 64'hA);
    compare_stream("leftover_discard", 1'b0);
    instr_ready = 1'b0;
    cycles = 0;
    while (!instr_valid && cycles < 64) begin
      @(negedge clk);
      cycles++;
    end
    if (!instr_valid) begin
      $display("leftover_discard: the straddling instruction at 0xA never showed up");
      errors++;
    end
    check_field("leftover_discard", "held pc", 64'hA, instr_pc);
    redirect_to(64'h30);
    build_model(64'h30, 64'h70);
    compare_stream("leftover_discard", 1'b0);
  endtask

  initial begin
    seed = 94;
    errors = 0;
    checks = 0;
    rst_n = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = REG_CTRL;
    cfg_wdata = '0;
    mem_rdata = '0;
    instr_ready = 1'b0;
    load_program();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    cfg_write(REG_CTRL, 64'd1);

    aligned_redirect();
    upper_half_target();
    random_backpressure();
    access_fault_window();
    misaligned_target();
    leftover_discard();

    assert_fails = fetch_top_inst.fetch_checker_inst.fail_count;
    $display("Checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* filelist.f */
design/fetch_pkg.sv
design/fetch_word_if.sv
design/fetch_instr_if.sv
design/fetch_ctrl_regs.sv
design/word_fetcher.sv
design/instr_aligner.sv
design/fetch_top.sv
test/fetch_checker.sv
test/fetch_tb.sv
